/* include/hdmi_init_config.svh */
`ifndef HDMI_INIT_CONFIG_SVH
`define HDMI_INIT_CONFIG_SVH

// register map of the wishbone i2c core
`define WB_ADR_PRER_LO  3'd0
`define WB_ADR_PRER_HI  3'd1
`define WB_ADR_CTR      3'd2
`define WB_ADR_TXRX     3'd3      // transmit on write, receive on read
`define WB_ADR_CRSR     3'd4      // command on write, status on read

`define PRER_LO_VAL     8'h8F     // scl prescaler low byte
`define PRER_HI_VAL     8'h01
`define CTR_ENABLE      8'h80     // core enable, no interrupt

`define CMD_START_WR        8'h90
`define CMD_STOP_WR         8'h50
`define CMD_WR              8'h10
`define CMD_READ_NACK_STOP  8'h68

`define SR_TIP_BIT      1         // transfer in progress
`define SR_RXACK_BIT    7         // slave did not acknowledge

// bus switch in front of the transmitter
`define SWITCH_ADDR     7'h74
`define SWITCH_DATA     8'h20     // hdmi channel only

`define HDMI_ADDR       7'h39
`define HPD_REG         8'h96     // bit 7 is hot-plug detect

`define ADV_REG_COUNT   63

`endif

/* design/i2c_core_pkg.sv */
package i2c_core_pkg;

   // request into the register port of the core
   typedef struct packed {
      logic [2:0] adr;
      logic [7:0] dat;
      logic       we;
      logic       stb;
      logic       cyc;
   } wb_req_t;

   // response of the core; dat always shows the addressed register
   typedef struct packed {
      logic [7:0] dat;
      logic       ack;    // not used by the driver
   } wb_rsp_t;

endpackage

/* design/hdmi_init_pkg.sv */
package hdmi_init_pkg;

   // one byte on the wire, either a slave address or plain data
   typedef union packed {
      struct packed {
         logic [6:0] dev;
         logic       rd;
      } addr;
      logic [7:0] data;
   } tx_byte_u;

   typedef enum logic [1:0] {
      START_ADDR,    // start, then write
      MID_BYTE,      // write only
      LAST_BYTE,     // write, then stop
      READ_BYTE      // read with nack, then stop
   } xfer_kind_e;

   typedef struct packed {
      xfer_kind_e kind;
      tx_byte_u   tx;
   } xfer_cmd_t;

   typedef struct packed {
      logic [7:0] addr;
      logic [7:0] value;
   } reg_entry_t;

   typedef enum logic [2:0] {
      PH_SW_WR,
      PH_SW_RD,
      PH_HPD,
      PH_CFG_WR,
      PH_CFG_RD,
      PH_DONE,
      PH_HALT
   } phase_e;

endpackage

/* design/i2c_core_driver.sv */
`timescale 1ns/10ps
`include "hdmi_init_config.svh"

module i2c_core_driver (
   input  logic                     clk,
   input  logic                     rst,
   input  hdmi_init_pkg::xfer_cmd_t cmd_i,
   input  logic                     start_i,
   output logic                     ready_o,
   output logic                     xfer_done_o,
   output logic [7:0]               rx_byte_o,
   output i2c_core_pkg::wb_req_t    wb_req_o,
   input  i2c_core_pkg::wb_rsp_t    wb_rsp_i
);
   import hdmi_init_pkg::*;

   typedef enum logic [3:0] {
      D_IDLE,
      D_SETUP,
      D_READY,
      D_LOAD,
      D_TX,
      D_CMD,
      D_TIP,
      D_ACK,
      D_RX
   } drv_state_e;

   drv_state_e state_q, state_d;
   logic [1:0] count_q;            // pacing counter
   logic       step_ok;
   logic [2:0] adr_q, adr_d;
   logic [7:0] dat_q, dat_d;
   logic       we;
   logic       done_q, done_d;
   logic       load_cmd;
   logic       capture;
   logic       tip;
   logic       rx_nack;
   xfer_cmd_t  cmd_q;
   logic [7:0] rx_q;

   function automatic logic [7:0] cmd_code(input xfer_kind_e kind);
      logic [7:0] code;
      case (kind)
         START_ADDR: code = `CMD_START_WR;
         MID_BYTE:   code = `CMD_WR;
         LAST_BYTE:  code = `CMD_STOP_WR;
         default:    code = `CMD_READ_NACK_STOP;
      endcase
      return code;
   endfunction

   assign step_ok = (count_q == 2'd0);
   assign tip     = wb_rsp_i.dat[`SR_TIP_BIT];
   assign rx_nack = wb_rsp_i.dat[`SR_RXACK_BIT];

   always_comb begin
      state_d  = state_q;
      adr_d    = adr_q;
      dat_d    = dat_q;
      we       = 1'b0;
      done_d   = 1'b0;
      load_cmd = 1'b0;
      capture  = 1'b0;
      case (state_q)
         D_IDLE: begin                       // one cycle with the bus idle
            state_d = D_SETUP;
            adr_d   = `WB_ADR_PRER_LO;
            dat_d   = `PRER_LO_VAL;
         end
         D_SETUP: begin
            we = 1'b1;
            if (wb_rsp_i.dat == dat_q && step_ok) begin   // readback matches
               case (adr_q)
                  `WB_ADR_PRER_LO: begin
                     adr_d = `WB_ADR_PRER_HI;
                     dat_d = `PRER_HI_VAL;
                  end
                  `WB_ADR_PRER_HI: begin
                     adr_d = `WB_ADR_CTR;
                     dat_d = `CTR_ENABLE;
                  end
                  default: state_d = D_READY;
               endcase
            end
         end
         D_READY: begin
            if (start_i) begin
               load_cmd = 1'b1;
               state_d  = D_LOAD;
            end
         end
         D_LOAD: begin                       // line up with the pacing counter
            if (step_ok) begin
               adr_d   = `WB_ADR_TXRX;
               dat_d   = cmd_q.tx.data;
               state_d = D_TX;
            end
         end
         D_TX: begin
            we = 1'b1;
            if (step_ok) begin
               adr_d   = `WB_ADR_CRSR;
               dat_d   = cmd_code(cmd_q.kind);
               state_d = D_CMD;
            end
         end
         D_CMD: begin
            we = 1'b1;                       // held until the core reports tip
            if (tip && step_ok) state_d = D_TIP;
         end
         D_TIP: begin
            if (!tip && step_ok) begin
               if (cmd_q.kind == READ_BYTE) begin
                  adr_d   = `WB_ADR_TXRX;    // receive register on read
                  state_d = D_RX;
               end else begin
                  state_d = D_ACK;
               end
            end
         end
         D_ACK: begin
            if (!rx_nack && step_ok) begin   // a nack keeps us here
               done_d  = 1'b1;
               state_d = D_READY;
            end
         end
         D_RX: begin
            if (step_ok) begin
               capture = 1'b1;
               done_d  = 1'b1;
               state_d = D_READY;
            end
         end
         default: state_d = D_IDLE;
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state_q <= D_IDLE;
         count_q <= 2'd0;
         adr_q   <= 3'd0;
         dat_q   <= 8'd0;
         done_q  <= 1'b0;
      end else begin
         state_q <= state_d;
         count_q <= count_q + 2'd1;          // free running
         adr_q   <= adr_d;
         dat_q   <= dat_d;
         done_q  <= done_d;
      end
   end

   always_ff @(posedge clk) begin
      if (load_cmd) cmd_q <= cmd_i;
      if (capture) rx_q <= wb_rsp_i.dat;
   end

   always_comb begin
      wb_req_o.adr = adr_q;
      wb_req_o.dat = dat_q;
      wb_req_o.we  = we;
      wb_req_o.stb = (state_q != D_IDLE);
      wb_req_o.cyc = (state_q != D_IDLE);
   end

   assign ready_o     = (state_q == D_READY);
   assign xfer_done_o = done_q;
   assign rx_byte_o   = rx_q;

endmodule

/* design/adv7511_reg_rom.sv */
`timescale 1ns/10ps

module adv7511_reg_rom (
   input  logic [5:0]                index_i,
   output hdmi_init_pkg::reg_entry_t entry_o
);

   // address, value
   always_comb begin
      case (index_i)
         6'd0:  entry_o = {8'h41, 8'h10};   // power up
         6'd1:  entry_o = {8'h0B, 8'hC7};   // spdif
         6'd2:  entry_o = {8'h14, 8'h02};   // audio word length 16
         6'd3:  entry_o = {8'h15, 8'h00};   // rgb 4:4:4 in
         6'd4:  entry_o = {8'h16, 8'h32};   // 8 bit, rising edge
         6'd5:  entry_o = {8'h17, 8'h60};   // sync polarity low
         6'd6:  entry_o = {8'h3C, 8'h02};   // vic
         6'd7:  entry_o = {8'h0A, 8'h10};   // spdif, mclk
         6'd8:  entry_o = {8'h55, 8'h00};   // rgb out
         6'd9:  entry_o = {8'h73, 8'h01};   // two audio channels
         6'd10: entry_o = {8'h9D, 8'h60};   // pixel clock undivided
         6'd11: entry_o = {8'hAF, 8'h06};   // hdmi mode, no hdcp
         6'd12: entry_o = {8'hD7, 8'h04};   // hsync front porch
         6'd13: entry_o = {8'hD8, 8'h03};
         6'd14: entry_o = {8'hD9, 8'hE0};
         6'd15: entry_o = {8'hDA, 8'h24};
         6'd16: entry_o = {8'hDB, 8'h06};
         6'd17: entry_o = {8'hF9, 8'h00};   // fixed i2c address
         // reserved registers with required values
         6'd18: entry_o = {8'h3B, 8'hE0};
         6'd19: entry_o = {8'h44, 8'h00};
         6'd20: entry_o = {8'h48, 8'h00};
         6'd21: entry_o = {8'h94, 8'hC0};
         6'd22: entry_o = {8'h96, 8'h00};
         6'd23: entry_o = {8'h98, 8'h03};
         6'd24: entry_o = {8'h99, 8'h02};
         6'd25: entry_o = {8'h9A, 8'hE0};
         6'd26: entry_o = {8'h9B, 8'h18};
         6'd27: entry_o = {8'h9C, 8'h30};
         6'd28: entry_o = {8'h9F, 8'h00};
         6'd29: entry_o = {8'hA1, 8'h00};
         6'd30: entry_o = {8'hA2, 8'hA4};
         6'd31: entry_o = {8'hA3, 8'hA4};
         6'd32: entry_o = {8'hA4, 8'h08};
         6'd33: entry_o = {8'hA5, 8'h04};
         6'd34: entry_o = {8'hA6, 8'h00};
         6'd35: entry_o = {8'hA7, 8'h00};
         6'd36: entry_o = {8'hA8, 8'h00};
         6'd37: entry_o = {8'hA9, 8'h00};
         6'd38: entry_o = {8'hAA, 8'h00};
         6'd39: entry_o = {8'hAB, 8'h40};
         6'd40: entry_o = {8'hB9, 8'h00};
         6'd41: entry_o = {8'hBA, 8'h00};
         6'd42: entry_o = {8'hBB, 8'h00};
         6'd43: entry_o = {8'hC7, 8'h00};
         6'd44: entry_o = {8'hCD, 8'h00};
         6'd45: entry_o = {8'hCE, 8'h01};
         6'd46: entry_o = {8'hCF, 8'h04};
         6'd47: entry_o = {8'hD0, 8'h3C};
         6'd48: entry_o = {8'hD1, 8'hFF};
         6'd49: entry_o = {8'hD2, 8'h80};
         6'd50: entry_o = {8'hD3, 8'h80};
         6'd51: entry_o = {8'hD4, 8'h80};
         6'd52: entry_o = {8'hD5, 8'h00};
         6'd53: entry_o = {8'hD6, 8'h00};
         6'd54: entry_o = {8'hDC, 8'h00};
         6'd55: entry_o = {8'hDD, 8'h00};
         6'd56: entry_o = {8'hDE, 8'h10};
         6'd57: entry_o = {8'hDF, 8'h01};
         6'd58: entry_o = {8'hE0, 8'h3C};
         6'd59: entry_o = {8'hE2, 8'h00};
         6'd60: entry_o = {8'hE3, 8'h00};
         6'd61: entry_o = {8'hE4, 8'h60};
         6'd62: entry_o = {8'hFA, 8'h00};   // last entry
         default: entry_o = '0;
      endcase
   end

endmodule

/* design/hdmi_init_sequencer.sv */
`timescale 1ns/10ps
`include "hdmi_init_config.svh"

module hdmi_init_sequencer (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      ready_i,
   input  logic                      xfer_done_i,
   input  logic [7:0]                rx_byte_i,
   output hdmi_init_pkg::xfer_cmd_t  cmd_o,
   output logic                      start_o,
   output logic [5:0]                index_o,
   input  hdmi_init_pkg::reg_entry_t entry_i,
   output logic                      iic_rst_o,
   output logic                      done_o,
   output logic [5:0]                error_cnt_o
);
   import hdmi_init_pkg::*;

   phase_e     phase_q;
   logic [1:0] step_q;            // byte within the phase
   logic [1:0] last_step;
   logic       busy_q;            // one transfer in flight
   logic [5:0] index_q;
   logic [5:0] error_q;
   logic       iic_rst_q;
   logic       active;
   logic [7:0] ptr;

   assign active = (phase_q != PH_DONE) && (phase_q != PH_HALT);
   assign ptr    = (phase_q == PH_HPD) ? `HPD_REG : entry_i.addr;

   // byte command for the current phase and step
   always_comb begin
      cmd_o.kind    = START_ADDR;
      cmd_o.tx.data = 8'd0;
      last_step     = 2'd1;
      case (phase_q)
         PH_SW_WR: begin
            if (step_q == 2'd0) begin
               cmd_o.tx.addr.dev = `SWITCH_ADDR;
               cmd_o.tx.addr.rd  = 1'b0;
            end else begin
               cmd_o.kind    = LAST_BYTE;
               cmd_o.tx.data = `SWITCH_DATA;
            end
         end
         PH_SW_RD: begin
            if (step_q == 2'd0) begin
               cmd_o.tx.addr.dev = `SWITCH_ADDR;
               cmd_o.tx.addr.rd  = 1'b1;
            end else begin
               cmd_o.kind = READ_BYTE;
            end
         end
         PH_CFG_WR: begin
            last_step = 2'd2;
            case (step_q)
               2'd0: begin
                  cmd_o.tx.addr.dev = `HDMI_ADDR;
                  cmd_o.tx.addr.rd  = 1'b0;
               end
               2'd1: begin
                  cmd_o.kind    = MID_BYTE;
                  cmd_o.tx.data = entry_i.addr;
               end
               default: begin
                  cmd_o.kind    = LAST_BYTE;
                  cmd_o.tx.data = entry_i.value;
               end
            endcase
         end
         PH_HPD, PH_CFG_RD: begin          // set the pointer, then read back
            last_step = 2'd3;
            case (step_q)
               2'd0: begin
                  cmd_o.tx.addr.dev = `HDMI_ADDR;
                  cmd_o.tx.addr.rd  = 1'b0;
               end
               2'd1: begin
                  cmd_o.kind    = MID_BYTE;
                  cmd_o.tx.data = ptr;
               end
               2'd2: begin                  // repeated start
                  cmd_o.tx.addr.dev = `HDMI_ADDR;
                  cmd_o.tx.addr.rd  = 1'b1;
               end
               default: cmd_o.kind = READ_BYTE;
            endcase
         end
         default: ;
      endcase
   end

   assign start_o = active && iic_rst_q && ready_i && !busy_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         phase_q   <= PH_SW_WR;
         step_q    <= 2'd0;
         busy_q    <= 1'b0;
         index_q   <= 6'd0;
         error_q   <= 6'd0;
         iic_rst_q <= 1'b0;
      end else begin
         iic_rst_q <= 1'b1;                 // switch leaves reset
         if (start_o) busy_q <= 1'b1;
         if (xfer_done_i) begin
            busy_q <= 1'b0;
            if (step_q != last_step) begin
               step_q <= step_q + 2'd1;
            end else begin
               step_q <= 2'd0;
               case (phase_q)
                  PH_SW_WR: phase_q <= PH_SW_RD;
                  PH_SW_RD: phase_q <= (rx_byte_i == `SWITCH_DATA) ? PH_HPD : PH_HALT;
                  PH_HPD: begin
                     if (rx_byte_i[7]) phase_q <= PH_CFG_WR;   // else poll again
                  end
                  PH_CFG_WR: phase_q <= PH_CFG_RD;
                  PH_CFG_RD: begin
                     if (rx_byte_i != entry_i.value) error_q <= error_q + 6'd1;
                     if (index_q == 6'(`ADV_REG_COUNT - 1)) begin
                        phase_q <= PH_DONE;
                     end else begin
                        index_q <= index_q + 6'd1;
                        phase_q <= PH_CFG_WR;
                     end
                  end
                  default: ;
               endcase
            end
         end
      end
   end

   assign index_o     = index_q;
   assign iic_rst_o   = iic_rst_q;
   assign done_o      = (phase_q == PH_DONE);
   assign error_cnt_o = error_q;

endmodule

/* design/hdmi_init_top.sv */
`timescale 1ns/10ps

module hdmi_init_top (
   input  logic                  clk,
   input  logic                  rst,
   output i2c_core_pkg::wb_req_t wb_req_o,
   input  i2c_core_pkg::wb_rsp_t wb_rsp_i,
   output logic                  iic_rst_o,
   output logic                  done_o,
   output logic [5:0]            error_cnt_o
);
   import hdmi_init_pkg::*;

   xfer_cmd_t  cmd;
   logic       start;
   logic       ready;
   logic       xfer_done;
   logic [7:0] rx_byte;
   logic [5:0] index;
   reg_entry_t entry;

   i2c_core_driver u_driver (
      .clk         (clk),
      .rst         (rst),
      .cmd_i       (cmd),
      .start_i     (start),
      .ready_o     (ready),
      .xfer_done_o (xfer_done),
      .rx_byte_o   (rx_byte),
      .wb_req_o    (wb_req_o),
      .wb_rsp_i    (wb_rsp_i)
   );

   adv7511_reg_rom u_rom (
      .index_i (index),
      .entry_o (entry)
   );

   hdmi_init_sequencer u_seq (
      .clk         (clk),
      .rst         (rst),
      .ready_i     (ready),
      .xfer_done_i (xfer_done),
      .rx_byte_i   (rx_byte),
      .cmd_o       (cmd),
      .start_o     (start),
      .index_o     (index),
      .entry_i     (entry),
      .iic_rst_o   (iic_rst_o),
      .done_o      (done_o),
      .error_cnt_o (error_cnt_o)
   );

endmodule

/* verification/i2c_core_model.sv */
`timescale 1ns/10ps
`include "hdmi_init_config.svh"

module i2c_core_model (
   input  logic                  clk,
   input  logic                  rst,
   input  i2c_core_pkg::wb_req_t wb_req_i,
   output i2c_core_pkg::wb_rsp_t wb_rsp_o,
   input  logic                  hpd_i,
   input  logic                  corrupt_i,
   input  logic [62:0]           mask_i
);
   import i2c_core_pkg::*;

   logic [7:0]  prer_lo, prer_hi, ctr, txr, rxr;
   logic [3:0]  tip_cnt;
   logic        cmd_busy;          // command already taken, wait for next tx byte
   logic [15:0] lfsr_q, s1, s2, s3;
   logic [6:0]  dev_q;
   logic        ptr_set;
   logic [7:0]  ptr_q;
   logic [7:0]  sw_reg, sw_at_first, last_addr;
   logic [7:0]  mem [256];
   logic [5:0]  ord [256];         // write order of each register
   int          wr_count, hpd_polls, setup_n;
   logic [2:0]  setup_adr [3];
   logic [7:0]  setup_dat [3];
   wb_req_t     prev_q;
   logic        wr;

   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   assign wr = wb_req_i.stb && wb_req_i.cyc && wb_req_i.we;

   always_comb begin
      s1 = lfsr_step(lfsr_q);
      s2 = lfsr_step(s1);
      s3 = lfsr_step(s2);
      case (wb_req_i.adr)
         `WB_ADR_PRER_LO: wb_rsp_o.dat = prer_lo;
         `WB_ADR_PRER_HI: wb_rsp_o.dat = prer_hi;
         `WB_ADR_CTR:     wb_rsp_o.dat = ctr;
         `WB_ADR_TXRX:    wb_rsp_o.dat = rxr;
         `WB_ADR_CRSR:    wb_rsp_o.dat = {6'd0, tip_cnt != 4'd0, 1'b0};  // never nack
         default:         wb_rsp_o.dat = 8'd0;
      endcase
      wb_rsp_o.ack = wb_req_i.stb;
   end

   always @(posedge clk or posedge rst) begin
      if (rst) begin
         {prer_lo, prer_hi, ctr, txr, rxr} <= '0;
         tip_cnt     <= 4'd0;
         cmd_busy    <= 1'b0;
         lfsr_q      <= 16'd71;
         dev_q       <= 7'd0;
         ptr_set     <= 1'b0;
         ptr_q       <= 8'd0;
         sw_reg      <= 8'd0;
         sw_at_first <= 8'd0;
         last_addr   <= 8'd0;
         wr_count    <= 0;
         hpd_polls   <= 0;
         setup_n     <= 0;
         prev_q      <= '0;
      end else begin
         prev_q <= wb_req_i;
         if (wr && setup_n < 3 && (!prev_q.we || prev_q.adr != wb_req_i.adr ||
                                   prev_q.dat != wb_req_i.dat)) begin
            setup_adr[setup_n] <= wb_req_i.adr;
            setup_dat[setup_n] <= wb_req_i.dat;
            setup_n            <= setup_n + 1;
         end
         // tip stays up while the command is still being written
         if (!(wr && wb_req_i.adr == `WB_ADR_CRSR) && tip_cnt != 4'd0)
            tip_cnt <= tip_cnt - 4'd1;
         if (wr) begin
            case (wb_req_i.adr)
               `WB_ADR_PRER_LO: prer_lo <= wb_req_i.dat;
               `WB_ADR_PRER_HI: prer_hi <= wb_req_i.dat;
               `WB_ADR_CTR:     ctr <= wb_req_i.dat;
               `WB_ADR_TXRX: begin
                  txr      <= wb_req_i.dat;
                  cmd_busy <= 1'b0;
               end
               `WB_ADR_CRSR: begin
                  if (!cmd_busy) begin
                     cmd_busy <= 1'b1;
                     tip_cnt  <= 4'd3 + {1'b0, s1[0], s2[0], s3[0]};   // 3 to 10
                     lfsr_q   <= s3;
                     case (wb_req_i.dat)
                        `CMD_START_WR: begin
                           dev_q <= txr[7:1];
                           if (!txr[0]) ptr_set <= 1'b0;   // new pointer follows
                        end
                        `CMD_WR, `CMD_STOP_WR: begin
                           if (dev_q == `SWITCH_ADDR) begin
                              sw_reg <= txr;
                           end else if (dev_q == `HDMI_ADDR && !ptr_set) begin
                              ptr_q   <= txr;
                              ptr_set <= 1'b1;
                           end else if (dev_q == `HDMI_ADDR) begin
                              mem[ptr_q] <= txr;
                              ord[ptr_q] <= 6'(wr_count);
                              if (wr_count == 0) sw_at_first <= sw_reg;
                              wr_count   <= wr_count + 1;
                              last_addr  <= ptr_q;
                              ptr_q      <= ptr_q + 8'd1;
                           end
                        end
                        `CMD_READ_NACK_STOP: begin
                           if (dev_q == `SWITCH_ADDR) begin
                              rxr <= corrupt_i ? ~sw_reg : sw_reg;
                           end else if (ptr_q == `HPD_REG && wr_count == 0) begin
                              rxr       <= {hpd_i, 7'd0};   // hot-plug poll
                              hpd_polls <= hpd_polls + 1;
                           end else begin
                              rxr <= mem[ptr_q] ^ {8{mask_i[ord[ptr_q]]}};
                           end
                        end
                        default: ;
                     endcase
                  end
               end
               default: ;
            endcase
         end
      end
   end

endmodule

/* verification/hdmi_init_asserts.sv */
`timescale 1ns/10ps

module hdmi_init_asserts (
   input logic                  clk,
   input logic                  rst,
   input i2c_core_pkg::wb_req_t wb_req_i,
   input logic                  iic_rst_i,
   input logic                  done_i,
   input logic [5:0]            error_cnt_i
);
   import i2c_core_pkg::*;

   int fail_count = 0;

   bus_idle_in_reset: assert property (@(posedge clk) rst |-> !wb_req_i.stb && !wb_req_i.cyc)
      else begin
         fail_count++;
         $error("wishbone strobe or cycle active during reset");
      end

   switch_reset_held: assert property (@(posedge clk) disable iff (rst)
      iic_rst_i |=> iic_rst_i)
      else begin
         fail_count++;
         $error("switch reset output dropped after release");
      end

   done_sticky: assert property (@(posedge clk) disable iff (rst) done_i |=> done_i)
      else begin
         fail_count++;
         $error("done fell without reset");
      end

   error_cnt_monotonic: assert property (@(posedge clk) disable iff (rst)
      error_cnt_i >= $past(error_cnt_i))
      else begin
         fail_count++;
         $error("error count went down");
      end

endmodule

/* verification/hdmi_init_tb.sv */
`timescale 1ns/10ps
`include "hdmi_init_config.svh"

module hdmi_init_tb;
   import i2c_core_pkg::*;

   localparam int NUM_TESTS       = 6;
   localparam int XFER_CYCLES     = 12 * 4 + 10;   // steps of four plus tip
   localparam int TEST_CYCLES     = 200 * XFER_CYCLES;
   localparam int WATCHDOG_CYCLES = TEST_CYCLES * NUM_TESTS;
   localparam int FAULT_WAIT      = 300 * XFER_CYCLES;   // longer than a clean run

   logic        clk;
   logic        rst;
   wb_req_t     wb_req;
   wb_rsp_t     wb_rsp;
   logic        iic_rst, done;
   logic [5:0]  error_cnt;
   logic        hpd, corrupt;
   logic [62:0] mask;
   logic [15:0] lfsr_q;
   logic [63:0] bits;
   logic        hpd_quiet;
   int          polls, errors, tests, errs_before;
   int          assert_seen;

   hdmi_init_top dut (
      .clk         (clk),
      .rst         (rst),
      .wb_req_o    (wb_req),
      .wb_rsp_i    (wb_rsp),
      .iic_rst_o   (iic_rst),
      .done_o      (done),
      .error_cnt_o (error_cnt)
   );

   i2c_core_model model (
      .clk       (clk),
      .rst       (rst),
      .wb_req_i  (wb_req),
      .wb_rsp_o  (wb_rsp),
      .hpd_i     (hpd),
      .corrupt_i (corrupt),
      .mask_i    (mask)
   );

   bind hdmi_init_top hdmi_init_asserts u_asserts (
      .clk         (clk),
      .rst         (rst),
      .wb_req_i    (wb_req_o),
      .iic_rst_i   (iic_rst_o),
      .done_i      (done_o),
      .error_cnt_i (error_cnt_o)
   );

   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic take_bits(input int n);
      bits = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_step(lfsr_q);
         bits   = {bits[62:0], lfsr_q[0]};
      end
   endtask

   task automatic apply_reset();
      @(posedge clk);
      rst <= 1'b1;
      repeat (8) @(posedge clk);
      rst <= 1'b0;
   endtask

   task automatic wait_done();
      while (!done) @(negedge clk);
   endtask

   task automatic check(input bit ok, input string msg);
      assert (ok) else begin
         $display("ERROR %0t: %s", $time, msg);
         errors++;
      end
   endtask

   task automatic end_test(input string name);
      errors += dut.u_asserts.fail_count - assert_seen;   // bound property failures
      assert_seen = dut.u_asserts.fail_count;
      tests++;
      $display("%s: %s", name, (errors == errs_before) ? "ok" : "failed");
      errs_before = errors;
   endtask

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("watchdog expired before all tests finished");
      $display("TEST FAILED");
      $finish;
   end

   initial begin
      rst         = 1'b1;
      hpd         = 1'b0;
      corrupt     = 1'b0;
      mask        = '0;
      lfsr_q      = 16'd71;
      errors      = 0;
      tests       = 0;
      errs_before = 0;
      assert_seen = 0;

      take_bits(3);
      polls = 2 + int'(bits[2:0]);
      apply_reset();
      // stops early if the transmitter is written while hot-plug is low
      while (model.hpd_polls < polls && model.wr_count == 0) @(negedge clk);
      hpd_quiet = (model.wr_count == 0);
      @(posedge clk);
      hpd <= 1'b1;
      wait_done();

      check(model.setup_n == 3, "fewer than three setup writes");
      check(model.setup_adr[0] == `WB_ADR_PRER_LO && model.setup_dat[0] == `PRER_LO_VAL,
            "first write is not the prescaler low byte");
      check(model.setup_adr[1] == `WB_ADR_PRER_HI && model.setup_dat[1] == `PRER_HI_VAL,
            "second write is not the prescaler high byte");
      check(model.setup_adr[2] == `WB_ADR_CTR && model.setup_dat[2] == `CTR_ENABLE,
            "third write is not the core enable");
      end_test("setup");
      check(model.sw_at_first == `SWITCH_DATA, "switch channel wrong at first config write");
      end_test("switch");
      check(hpd_quiet, "transmitter written before hot-plug was seen");
      end_test("hot-plug");
      check(error_cnt == 6'd0, "error count not zero on a clean run");
      check(model.wr_count == `ADV_REG_COUNT, "wrong number of transmitter writes");
      check(model.last_addr == 8'hFA, "last transmitter write not to register FA");
      end_test("clean configuration");

      take_bits(63);
      mask <= bits[62:0];   // applied before the reset pulse ends
      apply_reset();
      wait_done();
      check(int'(error_cnt) == $countones(mask), "error count differs from fault mask");
      end_test("readback faults");

      corrupt <= 1'b1;
      apply_reset();
      repeat (FAULT_WAIT) @(negedge clk);
      check(!done, "done raised after a switch mismatch");
      check(model.wr_count == 0, "transmitter written after a switch mismatch");
      end_test("switch fault");

      $display("%0d tests run, %0d errors", tests, errors);
      if (errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

/* files.f */
+incdir+include
design/i2c_core_pkg.sv
design/hdmi_init_pkg.sv
design/i2c_core_driver.sv
design/adv7511_reg_rom.sv
design/hdmi_init_sequencer.sv
design/hdmi_init_top.sv
verification/i2c_core_model.sv
verification/hdmi_init_asserts.sv
verification/hdmi_init_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f files.f --top-module hdmi_init_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/Vhdmi_init_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "TEST PASSED" "$LOG"; then
   exit 0
else
   exit 1
fi
